// File: build.f
rv_pkg.sv
rv_pipe_if.sv
rv_fetch.sv
rv_decode.sv
rv_branch_unit.sv
rv_execute.sv
rv_mem_wb.sv
rv_core_top.sv
tb_rv_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --assert -f build.f --top-module tb_rv_core -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_rv_core > "$log" 2>&1; then
  cat "$log"
  echo "simulation exited with an error"
  exit 1
fi

cat "$log"
if grep -q '\*\* FAIL \*\*' "$log"; then
  echo "simulation reported failure"
  exit 1
fi
exit 0

// File: rv_branch_unit.sv
`timescale 1ns/10ps

module rv_branch_unit import rv_pkg::*; (
  input  br_type_e  br_type,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  logic      is_store,
  input  word_t     if_id_pc,
  input  word_t     imm_b,
  input  word_t     imm_j,
  input  word_t     rf_rd1,
  input  word_t     rf_rd2,
  id_ex_if.ctrl_in  ex,
  fwd_if.consumer   fw,
  output logic      stall,
  output logic      taken,
  output word_t     target
);

  reg_addr_t src [2];
  word_t     rf_val [2];
  word_t     opnd [2];
  logic      is_branch, ex_load, load_use, load_br, cond;

  assign src[0]    = rs1_addr;
  assign src[1]    = rs2_addr;
  assign rf_val[0] = rf_rd1;
  assign rf_val[1] = rf_rd2;

  // newest producer wins, x0 never matches a live rd
  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      if (src[i] != '0 && ex.reg_write && ex.rd_addr == src[i])
        opnd[i] = fw.ex_alu_out;
      else if (src[i] != '0 && fw.ex_mem_reg_write && fw.ex_mem_rd == src[i])
        opnd[i] = fw.ex_mem_alu_out;
      else if (src[i] != '0 && fw.wb_reg_write && fw.wb_rd == src[i])
        opnd[i] = fw.wb_data;
      else
        opnd[i] = rf_val[i];
    end
  end

  assign is_branch = br_type != br_none && br_type != br_jal;
  assign ex_load   = ex.mem_rw == mem_read && ex.reg_write;

  // load in ID/EX; store data is patched later in the memory stage
  assign load_use = ex_load && (ex.rd_addr == rs1_addr || (ex.rd_addr == rs2_addr && !is_store));
  // second cycle of a load-branch stall, load now in EX/MEM
  assign load_br  = is_branch && fw.ex_mem_load && fw.ex_mem_reg_write &&
                    (fw.ex_mem_rd == rs1_addr || fw.ex_mem_rd == rs2_addr);
  assign stall    = load_use || load_br;

  always_comb
  begin
    case (br_type)
      br_eq:   cond = opnd[0] == opnd[1];
      br_ne:   cond = opnd[0] != opnd[1];
      br_lt:   cond = $signed(opnd[0]) < $signed(opnd[1]);
      br_ge:   cond = $signed(opnd[0]) >= $signed(opnd[1]);
      br_ltu:  cond = opnd[0] < opnd[1];
      br_geu:  cond = opnd[0] >= opnd[1];
      br_jal:  cond = 1'b1;
      default: cond = 1'b0;
    endcase
  end

  assign taken  = cond && !stall;  // operands are stale while stalled
  assign target = if_id_pc + ((br_type == br_jal) ? imm_j : imm_b);

endmodule

// File: rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top import rv_pkg::*; (
  input  logic                  CLK,
  input  logic                  arst_n,
  output logic                  I_MEM_CSN,
  input  word_t                 I_MEM_DI,
  output word_t                 I_MEM_ADDR,
  output logic                  D_MEM_CSN,
  input  word_t                 D_MEM_DI,
  output word_t                 D_MEM_DOUT,
  output word_t                 D_MEM_ADDR,
  output logic                  D_MEM_WEN,
  output logic                  RF_WE,
  output logic [reg_addr_w-1:0] RF_RA1,
  output logic [reg_addr_w-1:0] RF_RA2,
  output logic [reg_addr_w-1:0] RF_WA,
  input  word_t                 RF_RD1,
  input  word_t                 RF_RD2,
  output word_t                 RF_WD
);

  logic      stall, taken, is_store;
  word_t     target, if_id_inst, if_id_pc, imm_b, imm_j, rd1_byp, rd2_byp;
  reg_addr_t rs1_addr, rs2_addr, ex_mem_rs2_addr;
  br_type_e  br_type;
  word_t     ex_mem_store_data, ex_mem_pc;
  mem_rw_e   ex_mem_mem_rw;
  wb_from_e  ex_mem_wb_from;

  id_ex_if id_ex ();
  fwd_if   fw ();

  assign I_MEM_CSN = 1'b0;
  assign RF_RA1    = rs1_addr;
  assign RF_RA2    = rs2_addr;
  assign RF_WE     = fw.wb_reg_write;
  assign RF_WA     = fw.wb_rd;
  assign RF_WD     = fw.wb_data;

  // the register file is written at the end of writeback, too late for ID/EX
  assign rd1_byp = (fw.wb_reg_write && fw.wb_rd == rs1_addr) ? fw.wb_data : RF_RD1;
  assign rd2_byp = (fw.wb_reg_write && fw.wb_rd == rs2_addr) ? fw.wb_data : RF_RD2;

  rv_fetch u_fetch (
    .CLK(CLK), .arst_n(arst_n), .stall(stall), .taken(taken), .target(target),
    .i_mem_di(I_MEM_DI), .i_mem_addr(I_MEM_ADDR), .if_id_inst(if_id_inst), .if_id_pc(if_id_pc)
  );

  rv_decode u_decode (
    .CLK(CLK), .arst_n(arst_n), .if_id_inst(if_id_inst), .if_id_pc(if_id_pc), .stall(stall),
    .rf_rd1(rd1_byp), .rf_rd2(rd2_byp), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .br_type(br_type), .is_store(is_store), .imm_b(imm_b), .imm_j(imm_j), .ex(id_ex)
  );

  rv_branch_unit u_branch (
    .br_type(br_type), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .is_store(is_store),
    .if_id_pc(if_id_pc), .imm_b(imm_b), .imm_j(imm_j), .rf_rd1(RF_RD1), .rf_rd2(RF_RD2),
    .ex(id_ex), .fw(fw), .stall(stall), .taken(taken), .target(target)
  );

  rv_execute u_execute (
    .CLK(CLK), .arst_n(arst_n), .ex(id_ex), .load_data_fwd(D_MEM_DI), .fw(fw),
    .ex_mem_rs2_addr(ex_mem_rs2_addr), .ex_mem_store_data(ex_mem_store_data),
    .ex_mem_mem_rw(ex_mem_mem_rw), .ex_mem_wb_from(ex_mem_wb_from), .ex_mem_pc(ex_mem_pc)
  );

  rv_mem_wb u_mem_wb (
    .CLK(CLK), .arst_n(arst_n), .ex_mem_rs2_addr(ex_mem_rs2_addr),
    .ex_mem_store_data(ex_mem_store_data), .ex_mem_mem_rw(ex_mem_mem_rw),
    .ex_mem_wb_from(ex_mem_wb_from), .ex_mem_pc(ex_mem_pc), .d_mem_di(D_MEM_DI), .fw(fw),
    .d_mem_csn(D_MEM_CSN), .d_mem_wen(D_MEM_WEN), .d_mem_addr(D_MEM_ADDR),
    .d_mem_dout(D_MEM_DOUT)
  );

endmodule

// File: rv_decode.sv
`timescale 1ns/10ps

module rv_decode import rv_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n,
  input  word_t     if_id_inst,
  input  word_t     if_id_pc,
  input  logic      stall,
  input  word_t     rf_rd1,
  input  word_t     rf_rd2,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output br_type_e  br_type,
  output logic      is_store,
  output word_t     imm_b,
  output word_t     imm_j,
  id_ex_if.ctrl_out ex
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd_addr;
  word_t      imm_i, imm_s, imm_u, imm;
  alu_op_e    alu_op;
  alu_src2_e  alu_src2;
  mem_rw_e    mem_rw;
  wb_from_e   wb_from;
  logic       reg_write, use_rs1, use_rs2, valid;

  function automatic alu_op_e alu_decode(logic [2:0] f3, logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode  = opcode_e'(if_id_inst[opcode_w-1:0]);
  assign funct3  = if_id_inst[funct3_lsb +: 3];
  assign funct7  = if_id_inst[funct7_lsb +: 7];
  assign rd_addr = if_id_inst[rd_lsb +: reg_addr_w];

  assign imm_i = {{20{if_id_inst[31]}}, if_id_inst[31:20]};
  assign imm_s = {{20{if_id_inst[31]}}, if_id_inst[31:25], if_id_inst[11:7]};
  assign imm_b = {{19{if_id_inst[31]}}, if_id_inst[31], if_id_inst[7],
                  if_id_inst[30:25], if_id_inst[11:8], 1'b0};
  assign imm_u = {if_id_inst[31:12], 12'b0};
  assign imm_j = {{11{if_id_inst[31]}}, if_id_inst[31], if_id_inst[19:12],
                  if_id_inst[20], if_id_inst[30:21], 1'b0};

  always_comb
  begin
    valid     = 1'b1;
    alu_op    = alu_add;
    alu_src2  = src2_imm;
    mem_rw    = mem_none;
    wb_from   = wb_alu;
    reg_write = 1'b0;
    br_type   = br_none;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    imm       = imm_i;
    case (opcode)
      op_reg:
      begin
        {use_rs1, use_rs2, reg_write} = 3'b111;
        alu_src2 = src2_rs2;
        alu_op   = alu_decode(funct3, if_id_inst[alt_bit]);
        valid    = funct7 == 7'b0 || (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101});
      end
      op_imm:
      begin
        {use_rs1, reg_write} = 2'b11;
        alu_op = alu_decode(funct3, funct3 == 3'b101 && if_id_inst[alt_bit]);
        if (funct3 == 3'b001)
          valid = funct7 == 7'b0;
        else if (funct3 == 3'b101)
          valid = funct7 == 7'b0 || funct7 == 7'b0100000;
      end
      op_lui:
      begin
        reg_write = 1'b1;  // rs1 reads as x0, so the ALU adds to zero
        imm       = imm_u;
      end
      op_load:
      begin
        {use_rs1, reg_write} = 2'b11;
        mem_rw  = mem_read;
        wb_from = wb_mem;
        valid   = funct3 == 3'b010;  // lw only
      end
      op_store:
      begin
        {use_rs1, use_rs2} = 2'b11;
        mem_rw = mem_write;
        imm    = imm_s;
        valid  = funct3 == 3'b010;
      end
      op_branch:
      begin
        {use_rs1, use_rs2} = 2'b11;
        case (funct3)
          3'b000:  br_type = br_eq;
          3'b001:  br_type = br_ne;
          3'b100:  br_type = br_lt;
          3'b101:  br_type = br_ge;
          3'b110:  br_type = br_ltu;
          3'b111:  br_type = br_geu;
          default: valid = 1'b0;
        endcase
      end
      op_jal:
      begin
        reg_write = 1'b1;
        wb_from   = wb_pc;  // link is pc+4
        br_type   = br_jal;
      end
      default: valid = 1'b0;
    endcase
    if (!valid)  // anything unsupported runs as a bubble
    begin
      reg_write = 1'b0;
      mem_rw    = mem_none;
      br_type   = br_none;
      use_rs1   = 1'b0;
      use_rs2   = 1'b0;
    end
    if (rd_addr == '0)
      reg_write = 1'b0;
  end

  // unused sources read as x0 so they never match a hazard
  assign rs1_addr = use_rs1 ? if_id_inst[rs1_lsb +: reg_addr_w] : '0;
  assign rs2_addr = use_rs2 ? if_id_inst[rs2_lsb +: reg_addr_w] : '0;
  assign is_store = mem_rw == mem_write;

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ex.reg_write <= 1'b0;
      ex.mem_rw    <= mem_none;
    end
    else
    begin
      ex.reg_write <= reg_write && !stall;
      ex.mem_rw    <= stall ? mem_none : mem_rw;
    end
  end

  always_ff @(posedge CLK)
  begin
    ex.rs1_addr <= rs1_addr;
    ex.rs2_addr <= rs2_addr;
    ex.rd_addr  <= rd_addr;
    ex.rs1_data <= rf_rd1;
    ex.rs2_data <= rf_rd2;
    ex.imm      <= imm;
    ex.pc       <= if_id_pc;
    ex.alu_op   <= alu_op;
    ex.alu_src2 <= alu_src2;
    ex.wb_from  <= wb_from;
  end

endmodule

// File: rv_execute.sv
`timescale 1ns/10ps

module rv_execute import rv_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n,
  id_ex_if.ctrl_in  ex,
  input  word_t     load_data_fwd,  // word being read by the load in EX/MEM
  fwd_if.ex_side    fw,
  output reg_addr_t ex_mem_rs2_addr,
  output word_t     ex_mem_store_data,
  output mem_rw_e   ex_mem_mem_rw,
  output wb_from_e  ex_mem_wb_from,
  output word_t     ex_mem_pc
);

  reg_addr_t src [2];
  word_t     id_val [2];
  word_t     opnd [2];
  word_t     ex_mem_val, op2, alu_res;
  logic [4:0] shamt;

  assign src[0]    = ex.rs1_addr;
  assign src[1]    = ex.rs2_addr;
  assign id_val[0] = ex.rs1_data;
  assign id_val[1] = ex.rs2_data;

  // EX/MEM of a load holds the address, the data is on the memory bus
  assign ex_mem_val = fw.ex_mem_load ? load_data_fwd : fw.ex_mem_alu_out;

  always_comb
  begin
    for (int i = 0; i < 2; i++)
    begin
      if (src[i] != '0 && fw.ex_mem_reg_write && fw.ex_mem_rd == src[i])
        opnd[i] = ex_mem_val;
      else if (src[i] != '0 && fw.wb_reg_write && fw.wb_rd == src[i])
        opnd[i] = fw.wb_data;
      else
        opnd[i] = id_val[i];
    end
  end

  assign op2   = (ex.alu_src2 == src2_imm) ? ex.imm : opnd[1];
  assign shamt = op2[4:0];

  always_comb
  begin
    case (ex.alu_op)
      alu_sub:  alu_res = opnd[0] - op2;
      alu_and:  alu_res = opnd[0] & op2;
      alu_or:   alu_res = opnd[0] | op2;
      alu_xor:  alu_res = opnd[0] ^ op2;
      alu_sll:  alu_res = opnd[0] << shamt;
      alu_srl:  alu_res = opnd[0] >> shamt;
      alu_sra:  alu_res = word_t'($signed(opnd[0]) >>> shamt);
      alu_slt:  alu_res = word_t'($signed(opnd[0]) < $signed(op2));
      alu_sltu: alu_res = word_t'(opnd[0] < op2);
      default:  alu_res = opnd[0] + op2;
    endcase
  end

  // jal results in its link so bypassing hands out the right value
  assign fw.ex_alu_out  = (ex.wb_from == wb_pc) ? ex.pc + 32'd4 : alu_res;
  assign fw.ex_mem_load = ex_mem_mem_rw == mem_read;

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      fw.ex_mem_reg_write <= 1'b0;
      ex_mem_mem_rw       <= mem_none;
    end
    else
    begin
      fw.ex_mem_reg_write <= ex.reg_write;
      ex_mem_mem_rw       <= ex.mem_rw;
    end
  end

  always_ff @(posedge CLK)
  begin
    fw.ex_mem_rd      <= ex.rd_addr;
    fw.ex_mem_alu_out <= fw.ex_alu_out;  // address for loads and stores
    ex_mem_rs2_addr   <= ex.rs2_addr;
    ex_mem_store_data <= opnd[1];
    ex_mem_wb_from    <= ex.wb_from;
    ex_mem_pc         <= ex.pc;
  end

endmodule

// File: rv_fetch.sv
`timescale 1ns/10ps

module rv_fetch import rv_pkg::*; (
  input  logic  CLK,
  input  logic  arst_n,
  input  logic  stall,
  input  logic  taken,
  input  word_t target,
  input  word_t i_mem_di,
  output word_t i_mem_addr,
  output word_t if_id_inst,
  output word_t if_id_pc
);

  word_t pc;

  assign i_mem_addr = pc;  // memory answers in the same cycle

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
    begin
      pc         <= reset_pc;
      if_id_inst <= bubble_inst;
      if_id_pc   <= reset_pc;
    end
    else if (!stall)  // stall holds pc and IF/ID as they are
    begin
      pc         <= taken ? target : pc + 32'd4;
      if_id_inst <= taken ? bubble_inst : i_mem_di;  // squash the wrong-path fetch
      if_id_pc   <= pc;
    end
  end

  // a branch waiting on a load cannot resolve yet
  a_no_taken_in_stall: assert property (@(posedge CLK) disable iff (!arst_n)
    stall |-> !taken);

endmodule

// File: rv_mem_wb.sv
`timescale 1ns/10ps

module rv_mem_wb import rv_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n,
  input  reg_addr_t ex_mem_rs2_addr,
  input  word_t     ex_mem_store_data,
  input  mem_rw_e   ex_mem_mem_rw,
  input  wb_from_e  ex_mem_wb_from,
  input  word_t     ex_mem_pc,
  input  word_t     d_mem_di,
  fwd_if.wb_side    fw,
  output logic      d_mem_csn,
  output logic      d_mem_wen,
  output word_t     d_mem_addr,
  output word_t     d_mem_dout
);

  wb_from_e wb_from;
  word_t    wb_mem_data, wb_alu_out, wb_link;
  logic     ld_st_fwd;

  assign d_mem_csn  = ex_mem_mem_rw == mem_none;
  assign d_mem_wen  = ex_mem_mem_rw != mem_write;  // low means write
  assign d_mem_addr = fw.ex_mem_alu_out;

  // store right behind a load of its data register
  assign ld_st_fwd  = ex_mem_mem_rw == mem_write && wb_from == wb_mem &&
                      fw.wb_reg_write && fw.wb_rd == ex_mem_rs2_addr;
  assign d_mem_dout = ld_st_fwd ? wb_mem_data : ex_mem_store_data;

  always_ff @(posedge CLK or negedge arst_n)
  begin
    if (!arst_n)
      fw.wb_reg_write <= 1'b0;
    else
      fw.wb_reg_write <= fw.ex_mem_reg_write;
  end

  always_ff @(posedge CLK)
  begin
    fw.wb_rd    <= fw.ex_mem_rd;
    wb_from     <= ex_mem_wb_from;
    wb_mem_data <= d_mem_di;
    wb_alu_out  <= fw.ex_mem_alu_out;
    wb_link     <= ex_mem_pc + 32'd4;
  end

  always_comb
  begin
    case (wb_from)
      wb_mem:  fw.wb_data = wb_mem_data;
      wb_pc:   fw.wb_data = wb_link;
      default: fw.wb_data = wb_alu_out;
    endcase
  end

  // only word accesses exist, address comes from the execute stage
  a_word_aligned: assert property (@(posedge CLK) disable iff (!arst_n)
    !d_mem_csn |-> d_mem_addr[1:0] == 2'b00);

endmodule

// File: rv_pipe_if.sv
`timescale 1ns/10ps

// ID/EX pipeline register contents
interface id_ex_if import rv_pkg::*; ();
  reg_addr_t rs1_addr, rs2_addr, rd_addr;
  word_t     rs1_data, rs2_data, imm, pc;
  alu_op_e   alu_op;
  alu_src2_e alu_src2;
  mem_rw_e   mem_rw;
  wb_from_e  wb_from;
  logic      reg_write;

  modport ctrl_out (output rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm, pc,
                    alu_op, alu_src2, mem_rw, wb_from, reg_write);
  modport ctrl_in (input rs1_addr, rs2_addr, rd_addr, rs1_data, rs2_data, imm, pc,
                   alu_op, alu_src2, mem_rw, wb_from, reg_write);
endinterface

// results of the later stages, for bypassing and for the register file write
interface fwd_if import rv_pkg::*; ();
  word_t     ex_alu_out, ex_mem_alu_out, wb_data;
  reg_addr_t ex_mem_rd, wb_rd;
  logic      ex_mem_reg_write, ex_mem_load, wb_reg_write;

  modport ex_side (output ex_alu_out, ex_mem_rd, ex_mem_reg_write, ex_mem_load, ex_mem_alu_out,
                   input wb_rd, wb_reg_write, wb_data);
  modport wb_side (input ex_mem_rd, ex_mem_reg_write, ex_mem_alu_out,
                   output wb_rd, wb_reg_write, wb_data);
  modport consumer (input ex_alu_out, ex_mem_rd, ex_mem_reg_write, ex_mem_load, ex_mem_alu_out,
                    wb_rd, wb_reg_write, wb_data);
endinterface

// File: rv_pkg.sv
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int opcode_w   = 7;

  // instruction field positions
  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int funct7_lsb = 25;
  localparam int alt_bit    = 30;  // selects sub / sra

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  typedef enum logic [opcode_w-1:0] {
    op_reg    = 7'b0110011,
    op_imm    = 7'b0010011,
    op_lui    = 7'b0110111,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jal
  } br_type_e;

  typedef enum logic [1:0] {mem_none, mem_read, mem_write} mem_rw_e;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc} wb_from_e;
  typedef enum logic {src2_rs2, src2_imm} alu_src2_e;

  localparam word_t reset_pc    = '0;
  localparam word_t bubble_inst = 32'h0000_0013;  // addi x0, x0, 0

endpackage

// File: tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core import rv_pkg::*; ();

  localparam int imem_words   = 128;
  localparam int dmem_words   = 64;
  localparam int drain_cycles = 20;

  typedef struct {
    opcode_e    op;
    logic [2:0] f3;
    logic       alt;
    reg_addr_t  rd, rs1, rs2;
    word_t      imm;
  } inst_rec_t;

  logic      CLK, arst_n;
  logic      i_mem_csn, d_mem_csn, d_mem_wen, rf_we;
  word_t     i_mem_addr, i_mem_di, d_mem_addr, d_mem_dout, d_mem_di;
  word_t     rf_rd1, rf_rd2, rf_wd;
  reg_addr_t rf_ra1, rf_ra2, rf_wa;

  word_t       imem [imem_words];
  word_t       dmem [dmem_words];
  word_t       rf [32];
  inst_rec_t   prog [imem_words];
  logic [36:0] exp_wr [$];  // {rd, value}
  logic [63:0] exp_st [$];  // {address, data}
  logic [36:0] wr_head;
  logic [63:0] st_head;
  int          prog_len, mismatches, failures, post_reset_cycles, timeout_limit;

  rv_core_top dut0 (
    .CLK(CLK), .arst_n(arst_n), .I_MEM_CSN(i_mem_csn), .I_MEM_DI(i_mem_di),
    .I_MEM_ADDR(i_mem_addr), .D_MEM_CSN(d_mem_csn), .D_MEM_DI(d_mem_di),
    .D_MEM_DOUT(d_mem_dout), .D_MEM_ADDR(d_mem_addr), .D_MEM_WEN(d_mem_wen),
    .RF_WE(rf_we), .RF_RA1(rf_ra1), .RF_RA2(rf_ra2), .RF_WA(rf_wa),
    .RF_RD1(rf_rd1), .RF_RD2(rf_rd2), .RF_WD(rf_wd)
  );

  // memories and register file, all read combinationally
  assign i_mem_di = imem[i_mem_addr[8:2]];
  assign d_mem_di = dmem[d_mem_addr[7:2]];
  assign rf_rd1   = rf[rf_ra1];
  assign rf_rd2   = rf[rf_ra2];

  always @(posedge CLK)
  begin
    if (rf_we && rf_wa != '0)
      rf[rf_wa] <= rf_wd;
    if (!d_mem_csn && !d_mem_wen)
      dmem[d_mem_addr[7:2]] <= d_mem_dout;
  end

  function automatic word_t fill_word(int i);
    return 32'ha5a5_0000 ^ word_t'(i * 4);  // differs in every address bit
  endfunction

  function automatic word_t encode(inst_rec_t r);
    case (r.op)
      op_reg:    return {1'b0, r.alt, 5'b0, r.rs2, r.rs1, r.f3, r.rd, r.op};
      op_imm:
      begin
        if (r.f3 == 3'b001 || r.f3 == 3'b101)
          return {1'b0, r.alt, 5'b0, r.imm[4:0], r.rs1, r.f3, r.rd, r.op};
        return {r.imm[11:0], r.rs1, r.f3, r.rd, r.op};
      end
      op_lui:    return {r.imm[31:12], r.rd, r.op};
      op_load:   return {r.imm[11:0], r.rs1, 3'b010, r.rd, r.op};
      op_store:  return {r.imm[11:5], r.rs2, r.rs1, 3'b010, r.imm[4:0], r.op};
      op_branch: return {r.imm[12], r.imm[10:5], r.rs2, r.rs1, r.f3, r.imm[4:1], r.imm[11], r.op};
      default:   return {r.imm[20], r.imm[10:1], r.imm[11], r.imm[19:12], r.rd, r.op};
    endcase
  endfunction

  task automatic add_inst(opcode_e op, int f3, int alt, int rd, int rs1, int rs2, int imm);
    prog[prog_len].op  = op;
    prog[prog_len].f3  = 3'(f3);
    prog[prog_len].alt = alt != 0;
    prog[prog_len].rd  = reg_addr_t'(rd);
    prog[prog_len].rs1 = reg_addr_t'(rs1);
    prog[prog_len].rs2 = reg_addr_t'(rs2);
    prog[prog_len].imm = word_t'(imm);
    imem[prog_len]     = encode(prog[prog_len]);
    prog_len++;
  endtask

  task automatic build_program();
    int br_f3 [6] = '{0, 1, 4, 5, 6, 7};
    int opnd_a [3] = '{1, 13, 1};
    int opnd_b [3] = '{13, 1, 1};
    int rd, rs1, rs2, f3, alt, imm;
    prog_len = 0;
    add_inst(op_imm, 0, 0, 1, 0, 0, 5);
    add_inst(op_imm, 0, 0, 2, 1, 0, 3);       // back to back
    add_inst(op_reg, 0, 0, 3, 1, 2, 0);
    add_inst(op_reg, 0, 1, 4, 3, 1, 0);       // sub
    add_inst(op_lui, 0, 0, 5, 0, 0, 32'h1234_5000);
    add_inst(op_imm, 0, 0, 6, 0, 0, 64);      // data base address
    add_inst(op_store, 0, 0, 0, 6, 3, 0);
    add_inst(op_load, 0, 0, 7, 6, 0, 0);
    add_inst(op_reg, 0, 0, 8, 7, 1, 0);       // load-use
    add_inst(op_load, 0, 0, 9, 6, 0, 0);
    add_inst(op_branch, 0, 0, 0, 9, 3, 8);    // load then branch on the loaded word
    add_inst(op_imm, 0, 0, 10, 0, 0, 1);
    add_inst(op_load, 0, 0, 11, 6, 0, 8);
    add_inst(op_store, 0, 0, 0, 6, 11, 12);   // load then store of its data
    add_inst(op_load, 0, 0, 12, 6, 0, 12);
    add_inst(op_imm, 0, 0, 13, 0, 0, -3);
    // every branch kind against 5 / -3 pairs, the skipped addi counts untaken ones
    for (int i = 0; i < 6; i++)
    begin
      for (int j = 0; j < 3; j++)
      begin
        add_inst(op_branch, br_f3[i], 0, 0, opnd_a[j], opnd_b[j], 8);
        add_inst(op_imm, 0, 0, 14, 14, 0, 1);
      end
    end
    add_inst(op_jal, 0, 0, 15, 0, 0, 8);
    add_inst(op_imm, 0, 0, 16, 0, 0, 9);      // wrong path
    add_inst(op_reg, 0, 0, 16, 15, 0, 0);     // uses the link
    for (int n = 0; n < 60; n++)
    begin
      rd  = $urandom % 32;
      rs1 = $urandom % 32;
      rs2 = $urandom % 32;
      f3  = $urandom % 8;
      if ($urandom % 2 == 0)
      begin
        alt = (f3 == 0 || f3 == 5) ? $urandom % 2 : 0;
        add_inst(op_reg, f3, alt, rd, rs1, rs2, 0);
      end
      else
      begin
        imm = (f3 == 1 || f3 == 5) ? $urandom % 32 : int'($urandom % 4096) - 2048;
        alt = (f3 == 5) ? $urandom % 2 : 0;
        add_inst(op_imm, f3, alt, rd, rs1, 0, imm);
      end
    end
    add_inst(op_jal, 0, 0, 0, 0, 0, 0);       // spin here
  endtask

  function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // in-order model of the program, fills the expected queues
  task automatic run_reference();
    word_t     x [32];
    word_t     mem [dmem_words];
    inst_rec_t r;
    word_t     v, addr;
    logic      wr;
    int        k, next, steps;
    for (int i = 0; i < 32; i++)
      x[i] = '0;
    for (int i = 0; i < dmem_words; i++)
      mem[i] = fill_word(i);
    k     = 0;
    steps = 0;
    while (k != prog_len - 1 && steps < 1000)
    begin
      r    = prog[k];
      next = k + 1;
      wr   = 1'b1;
      v    = '0;
      addr = x[r.rs1] + r.imm;
      case (r.op)
        op_reg:  v = alu_ref(r.f3, r.alt, x[r.rs1], x[r.rs2]);
        op_imm:  v = alu_ref(r.f3, r.alt, x[r.rs1], r.imm);
        op_lui:  v = r.imm;
        op_load: v = mem[addr[7:2]];
        op_store:
        begin
          wr = 1'b0;
          exp_st.push_back({addr, x[r.rs2]});
          mem[addr[7:2]] = x[r.rs2];
        end
        op_branch:
        begin
          wr = 1'b0;
          if (branch_ref(r.f3, x[r.rs1], x[r.rs2]))
            next = k + int'(r.imm) / 4;
        end
        default:
        begin
          v    = word_t'(k * 4 + 4);  // jal link
          next = k + int'(r.imm) / 4;
        end
      endcase
      if (wr && r.rd != '0)
      begin
        x[r.rd] = v;
        exp_wr.push_back({r.rd, v});
      end
      k = next;
      steps++;
    end
  endtask

  always @(posedge CLK)
  begin
    if (arst_n)
    begin
      if (post_reset_cycles < 4)
        assert (!rf_we && d_mem_csn) else
        begin
          failures++;
          $display("register write or data memory access before the first writeback");
        end
      assert (!i_mem_csn) else
      begin
        failures++;
        $display("instruction memory deselected while the core runs");
      end
      assert (!(rf_we && rf_wa == '0)) else
      begin
        failures++;
        $display("register write enabled with x0 as destination");
      end
      if (rf_we && rf_wa != '0)
      begin
        assert (exp_wr.size() != 0) else
        begin
          failures++;
          $display("register write to x%0d when none was expected", rf_wa);
        end
        if (exp_wr.size() != 0)
        begin
          wr_head = exp_wr.pop_front();
          assert (rf_wa == wr_head[36:32]) else
          begin
            mismatches++;
            $display("Mismatch RF_WA: got %h, expected %h", rf_wa, wr_head[36:32]);
          end
          assert (rf_wd == wr_head[31:0]) else
          begin
            mismatches++;
            $display("Mismatch RF_WD: got %h, expected %h", rf_wd, wr_head[31:0]);
          end
        end
      end
      if (!d_mem_csn && !d_mem_wen)
      begin
        assert (exp_st.size() != 0) else
        begin
          failures++;
          $display("store to address %h when none was expected", d_mem_addr);
        end
        if (exp_st.size() != 0)
        begin
          st_head = exp_st.pop_front();
          assert (d_mem_addr == st_head[63:32]) else
          begin
            mismatches++;
            $display("Mismatch D_MEM_ADDR: got %h, expected %h", d_mem_addr, st_head[63:32]);
          end
          assert (d_mem_dout == st_head[31:0]) else
          begin
            mismatches++;
            $display("Mismatch D_MEM_DOUT: got %h, expected %h", d_mem_dout, st_head[31:0]);
          end
        end
      end
      post_reset_cycles++;
    end
  end

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    wait (arst_n === 1'b1);
    while (cycles < timeout_limit)
    begin
      @(posedge CLK);
      cycles++;
    end
    failures++;
    $display("timeout after %0d cycles, %0d writes and %0d stores never seen",
             cycles, exp_wr.size(), exp_st.size());
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    arst_n            = 1'b0;
    mismatches        = 0;
    failures          = 0;
    post_reset_cycles = 0;
    void'($urandom(32'ha7422c28));
    for (int i = 0; i < imem_words; i++)
      imem[i] = bubble_inst;
    for (int i = 0; i < dmem_words; i++)
      dmem[i] <= fill_word(i);
    for (int i = 0; i < 32; i++)
      rf[i] <= '0;
    build_program();
    run_reference();
    timeout_limit = 3 * prog_len + 40;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    arst_n = 1'b1;
    while (exp_wr.size() != 0 || exp_st.size() != 0)
      @(posedge CLK);
    repeat (drain_cycles) @(posedge CLK);  // any late write shows up as unexpected
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches + failures == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
